// File: flist.f
src/nes_dma_pkg.sv
src/dma_cycle_timer.sv
src/dmc_dma_slot.sv
src/oam_dma_engine.sv
src/cpu_bus_arbiter.sv
src/nes_dma_top.sv
bench/nes_dma_tb.sv

// File: run.sh
#!/bin/bash
# Builds the NES DMA testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -f flist.f --top-module nes_dma_tb -Mdir obj_dir -o nes_dma_sim \
	&& ./obj_dir/nes_dma_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

// File: bench/nes_dma_tb.sv
// NES DMA unit testbench
// CPU and memory models, sprite and DMC stimulus, assertion based checking
module nes_dma_tb
	import nes_dma_pkg::*;
();

	logic     clk;
	logic     reset;
	cpu_bus_t cpu_req;
	byte_t    mem_rdata;
	logic     dmc_req;
	addr_t    dmc_addr;
	cpu_bus_t mem_bus;
	logic     dma_owns_bus;
	logic     pause_cpu;
	logic     dmc_ack;
	logic     cpu_ce;

	// Expected sprite sequence, advanced at the end of each CPU cycle
	logic        sprite_running;
	byte_t       exp_page;
	logic [8:0]  exp_index;      // Bytes written so far
	logic        expect_read;    // Next sprite cycle is the read half
	logic        tb_odd;         // Cycle parity, odd right after reset
	logic        sprite_cycle;   // Sprite DMA drives the bus
	addr_t       exp_rd_addr;
	int          ce_clks;        // Clocks since reset fell
	int          errors;
	int          timeouts;
	logic [31:0] rng;

	nes_dma_top nes_dma_top_inst (
		.clk          (clk),
		.reset        (reset),
		.cpu_req      (cpu_req),
		.mem_rdata    (mem_rdata),
		.dmc_req      (dmc_req),
		.dmc_addr     (dmc_addr),
		.mem_bus      (mem_bus),
		.dma_owns_bus (dma_owns_bus),
		.pause_cpu    (pause_cpu),
		.dmc_ack      (dmc_ack),
		.cpu_ce       (cpu_ce)
	);

	always #10 clk = ~clk;

	// Memory contents as a function of the full address
	function automatic byte_t mem_value(input addr_t a);
		return a[15:8] ^ a[7:0] ^ 8'h5A;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign mem_rdata = mem_value(mem_bus.addr);   // Combinational memory
	assign sprite_cycle = dma_owns_bus && !dmc_ack;
	assign exp_rd_addr = {exp_page, exp_index[7:0]};

	// Clock count for the CPU enable cadence
	always @(posedge clk) begin
		if (reset)
			ce_clks <= 0;
		else
			ce_clks <= ce_clks + 1;
	end

	// Scoreboard follows the bus at each CPU cycle boundary
	always @(posedge clk) begin
		if (reset) begin
			sprite_running <= 1'b0;
			exp_page <= 8'h00;
			exp_index <= 9'd0;
			expect_read <= 1'b1;
			tb_odd <= 1'b1;
		end else if (cpu_ce) begin
			tb_odd <= ~tb_odd;
			if (!sprite_running && !mem_bus.rnw && mem_bus.addr == 16'h4014) begin
				sprite_running <= 1'b1;   // Trigger write seen
				exp_page <= mem_bus.data;
				exp_index <= 9'd0;
				expect_read <= 1'b1;
			end else if (sprite_cycle && expect_read) begin
				expect_read <= 1'b0;
			end else if (sprite_cycle) begin
				expect_read <= 1'b1;
				exp_index <= exp_index + 9'd1;
				if (exp_index == 9'd255)
					sprite_running <= 1'b0;   // Last byte out
			end
		end
	end

	// Quiet outputs once reset drops
	assert property (@(negedge clk) $fell(reset) |->
		{dma_owns_bus, pause_cpu, dmc_ack, cpu_ce} == 4'b0000)
		else value_error("dma_owns_bus,pause_cpu,dmc_ack,cpu_ce",
			32'({dma_owns_bus, pause_cpu, dmc_ack, cpu_ce}), 32'd0);
	// One enable pulse every 12 clocks, first one 12 clocks after reset
	assert property (@(negedge clk) disable iff (reset)
		cpu_ce == (ce_clks != 0 && ce_clks % 12 == 0))
		else value_error("cpu_ce", 32'(cpu_ce), 32'(ce_clks != 0 && ce_clks % 12 == 0));
	assert property (@(negedge clk) disable iff (reset)
		!dma_owns_bus |-> mem_bus == cpu_req)
		else value_error("mem_bus", 32'(mem_bus), 32'(cpu_req));
	assert property (@(negedge clk) disable iff (reset)
		pause_cpu == (sprite_running || dmc_req))
		else value_error("pause_cpu", 32'(pause_cpu), 32'(sprite_running || dmc_req));
	assert property (@(negedge clk) disable iff (reset)
		sprite_cycle |-> sprite_running)
		else report_failure("sprite DMA owns the bus with no copy expected");
	// Page read on even cycles
	assert property (@(negedge clk) disable iff (reset)
		cpu_ce && sprite_cycle && expect_read |->
		{mem_bus.addr, mem_bus.rnw} == {exp_rd_addr, 1'b1})
		else value_error("mem_bus.addr,rnw", 32'({mem_bus.addr, mem_bus.rnw}),
			32'({exp_rd_addr, 1'b1}));
	// OAM write on odd cycles
	assert property (@(negedge clk) disable iff (reset)
		cpu_ce && sprite_cycle && !expect_read |->
		{mem_bus.addr, mem_bus.rnw} == {16'h2004, 1'b0})
		else value_error("mem_bus.addr,rnw", 32'({mem_bus.addr, mem_bus.rnw}),
			32'({16'h2004, 1'b0}));
	assert property (@(negedge clk) disable iff (reset)
		cpu_ce && sprite_cycle && !expect_read |-> mem_bus.data == mem_value(exp_rd_addr))
		else value_error("mem_bus.data", 32'(mem_bus.data), 32'(mem_value(exp_rd_addr)));
	assert property (@(negedge clk) disable iff (reset)
		cpu_ce && sprite_cycle |-> tb_odd == !expect_read)
		else value_error("cycle parity", 32'(tb_odd), 32'(!expect_read));
	// DMC fetch is a read of dmc_addr on a requested even cycle
	assert property (@(negedge clk) disable iff (reset)
		cpu_ce && dmc_ack |-> {mem_bus.addr, mem_bus.rnw} == {dmc_addr, 1'b1})
		else value_error("mem_bus.addr,rnw", 32'({mem_bus.addr, mem_bus.rnw}),
			32'({dmc_addr, 1'b1}));
	assert property (@(negedge clk) disable iff (reset)
		cpu_ce && dmc_ack |-> dmc_req && !tb_odd)
		else report_failure("dmc_ack outside a requested even cycle");

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic finish_run();
		$display("Summary: %0d assertion errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t: no %s", $time, what);
		finish_run();
	endtask

	// Ends on the clock after the cpu_ce that closes the current CPU cycle
	task automatic next_cpu_cycle(output logic paused);
		int n;
		n = 0;
		@(negedge clk);
		while (!cpu_ce && n < 30) begin
			n++;
			@(negedge clk);
		end
		if (!cpu_ce)
			abort_on_timeout("cpu_ce pulse");
		paused = pause_cpu;   // Seen at the cycle end
		@(posedge clk);
		#1;
	endtask

	// One CPU bus access, a read waits out any pause, then back to idle reads
	task automatic cpu_access(input addr_t a, input byte_t d, input logic rnw);
		logic paused;
		int n;
		cpu_req = {a, d, rnw};
		n = 0;
		next_cpu_cycle(paused);
		while (paused && rnw && n < 2000) begin
			n++;
			next_cpu_cycle(paused);
		end
		if (paused && rnw)
			abort_on_timeout("end of the CPU pause");
		cpu_req = {16'h0000, 8'h00, 1'b1};
	endtask

	task automatic dmc_fetch(input addr_t a);
		int n;
		dmc_addr = a;
		dmc_req = 1'b1;
		n = 0;
		@(negedge clk);
		while (!(cpu_ce && dmc_ack) && n < 200) begin
			n++;
			@(negedge clk);
		end
		if (!(cpu_ce && dmc_ack))
			abort_on_timeout("dmc_ack for a DMC request");
		@(posedge clk);
		#1;
		dmc_req = 1'b0;   // Requester lets go after the ack
	endtask

	task automatic sprite_copy(input byte_t page, input logic with_dmc);
		logic paused;
		int gap;
		int n;
		cpu_access(16'h4014, page, 1'b0);
		n = 0;
		while (sprite_running && n < 800) begin
			n++;
			if (with_dmc) begin
				rng = xorshift32(rng);
				gap = 1 + int'(rng[4:0]);   // Random point within the copy
				repeat (gap) next_cpu_cycle(paused);
				rng = xorshift32(rng);
				dmc_fetch(rng[15:0]);
			end else begin
				next_cpu_cycle(paused);
			end
		end
		if (sprite_running)
			abort_on_timeout("end of sprite DMA");
	endtask

	initial begin
		logic paused;
		addr_t a;
		clk = 1'b0;
		reset = 1'b1;
		cpu_req = {16'h0000, 8'h00, 1'b1};
		dmc_req = 1'b0;
		dmc_addr = 16'h0000;
		errors = 0;
		timeouts = 0;
		rng = 32'h9c2dd705;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		// Plain CPU traffic, writes included, none to the trigger
		repeat (8) begin
			rng = xorshift32(rng);
			a = rng[15:0];
			if (a == 16'h4014)
				a = 16'h4015;
			cpu_access(a, rng[23:16], rng[24]);
		end
		cpu_access(16'h4015, 8'h0F, 1'b0);
		cpu_access(16'h2004, 8'hA5, 1'b0);
		// DMC fetches on an idle bus
		repeat (2) begin
			rng = xorshift32(rng);
			dmc_fetch(rng[15:0]);
			repeat (3) next_cpu_cycle(paused);
		end
		rng = xorshift32(rng);
		sprite_copy(rng[7:0], 1'b0);
		cpu_access(16'h0123, 8'h00, 1'b1);
		// Copies with DMC steals
		repeat (2) begin
			rng = xorshift32(rng);
			sprite_copy(rng[15:8], 1'b1);
			cpu_access(rng[31:16], 8'h00, 1'b1);
		end
		finish_run();
	end

endmodule

// File: src/nes_dma_top.sv
// NES CPU side DMA unit
// Cycle timer, sprite and DMC DMA engines and the memory bus arbiter
module nes_dma_top
	import nes_dma_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  cpu_bus_t cpu_req,        // From the CPU
	input  byte_t    mem_rdata,      // Memory read data for mem_bus.addr
	input  logic     dmc_req,
	input  addr_t    dmc_addr,
	output cpu_bus_t mem_bus,
	output logic     dma_owns_bus,
	output logic     pause_cpu,      // CPU ready low
	output logic     dmc_ack,
	output logic     cpu_ce
);

	logic     odd_cycle;
	logic     start;
	logic     copy_active;
	logic     armed;
	cpu_bus_t oam_bus;

	dma_cycle_timer dma_cycle_timer_inst (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dmc_dma_slot dmc_dma_slot_inst (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle),
		.cpu_rnw   (cpu_req.rnw),
		.dmc_req   (dmc_req),
		.dmc_ack   (dmc_ack)
	);

	oam_dma_engine oam_dma_engine_inst (
		.clk         (clk),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.odd_cycle   (odd_cycle),
		.start       (start),
		.page        (cpu_req.data),   // Page number comes with the trigger write
		.cpu_rnw     (cpu_req.rnw),
		.dmc_ack     (dmc_ack),
		.mem_rdata   (mem_rdata),
		.copy_active (copy_active),
		.armed       (armed),
		.oam_bus     (oam_bus)
	);

	cpu_bus_arbiter cpu_bus_arbiter_inst (
		.cpu_req      (cpu_req),
		.oam_bus      (oam_bus),
		.copy_active  (copy_active),
		.armed        (armed),
		.dmc_ack      (dmc_ack),
		.dmc_req      (dmc_req),
		.dmc_addr     (dmc_addr),
		.start        (start),
		.mem_bus      (mem_bus),
		.dma_owns_bus (dma_owns_bus),
		.pause_cpu    (pause_cpu)
	);

endmodule

// File: src/cpu_bus_arbiter.sv
// CPU bus arbiter
// Picks the bus owner (DMC, sprite DMA, CPU), decodes the trigger, makes pause_cpu
module cpu_bus_arbiter
	import nes_dma_pkg::*;
(
	input  cpu_bus_t cpu_req,        // CPU side request
	input  cpu_bus_t oam_bus,        // Sprite DMA request
	input  logic     copy_active,
	input  logic     armed,
	input  logic     dmc_ack,
	input  logic     dmc_req,
	input  addr_t    dmc_addr,       // DMC sample address
	output logic     start,          // Trigger write seen on the bus
	output cpu_bus_t mem_bus,
	output logic     dma_owns_bus,
	output logic     pause_cpu
);

	cpu_bus_t dmc_bus;   // DMC fetch is always a read

	always_comb begin
		dmc_bus.addr = dmc_addr;
		dmc_bus.data = cpu_req.data;   // Don't care on a read
		dmc_bus.rnw = 1'b1;
	end

	// Priority select
	always_comb begin
		if (dmc_ack)
			mem_bus = dmc_bus;
		else if (copy_active)
			mem_bus = oam_bus;
		else
			mem_bus = cpu_req;
	end

	assign dma_owns_bus = dmc_ack || copy_active;

	// Decoded from the selected bus
	// DMA never writes the trigger so only the CPU can start a copy
	assign start = !mem_bus.rnw && (mem_bus.addr == OAM_TRIGGER_ADDR);

	// Hold the CPU during any sprite phase and while a DMC fetch is pending
	assign pause_cpu = armed || copy_active || dmc_req;

endmodule

// File: src/oam_dma_engine.sv
// Sprite (OAM) DMA engine
// Copies a 256 byte page to the PPU OAM port, read on even cycles, write on odd
module oam_dma_engine
	import nes_dma_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     cpu_ce,
	input  logic     odd_cycle,
	input  logic     start,         // CPU wrote the trigger register
	input  byte_t    page,          // Source page from the CPU write data
	input  logic     cpu_rnw,
	input  logic     dmc_ack,       // DMC took this even cycle
	input  byte_t    mem_rdata,
	output logic     copy_active,   // Engine drives the bus
	output logic     armed,         // Waiting to start or resume
	output cpu_bus_t oam_bus
);

	oam_state_e state;
	byte_t      src_page;   // High byte of the source address
	byte_t      index;      // Byte within the page
	byte_t      data_latch; // Byte in flight from read to write

	// Owned even cycle that actually reads sprite data
	logic rd_cycle;
	logic wr_cycle;

	assign rd_cycle = (state == OAM_COPY) && !odd_cycle && !dmc_ack;
	assign wr_cycle = (state == OAM_COPY) && odd_cycle;

	// Control FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= OAM_IDLE;
		end else if (cpu_ce) begin
			case (state)
				OAM_IDLE: begin
					if (start)
						state <= OAM_ARMED;
				end
				OAM_ARMED: begin
					// CPU halts on a read, then the copy starts on an even cycle
					if (cpu_rnw && odd_cycle)
						state <= OAM_COPY;
				end
				OAM_COPY: begin
					if (!odd_cycle && dmc_ack)
						state <= OAM_ARMED;   // Lost the read, idle odd cycle follows
					else if (odd_cycle && index == 8'hFF)
						state <= OAM_IDLE;    // Last byte written
				end
				default: state <= OAM_IDLE;
			endcase
		end
	end

	// Address counter and data latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (start && state == OAM_IDLE) begin
				src_page <= page;
				index <= 8'h00;
			end
			if (rd_cycle)
				data_latch <= mem_rdata;
			if (wr_cycle)
				index <= index + 8'h01;   // Stalls through a DMC steal
		end
	end

	assign copy_active = (state == OAM_COPY);
	assign armed = (state == OAM_ARMED);

	// Read from the page on even cycles, write to OAM on odd ones
	always_comb begin
		oam_bus.addr = odd_cycle ? OAM_DATA_ADDR : {src_page, index};
		oam_bus.data = data_latch;
		oam_bus.rnw = !odd_cycle;
	end

endmodule

// File: src/dmc_dma_slot.sv
// DMC sample DMA slot
// Grants one even CPU read cycle to each DMC fetch request
module dmc_dma_slot
	import nes_dma_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic cpu_ce,
	input  logic odd_cycle,
	input  logic cpu_rnw,     // CPU is in a read cycle
	input  logic dmc_req,     // Fetch wanted, held until acked
	output logic dmc_ack      // High for the stolen cycle
);

	dmc_state_e state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DMC_IDLE;
		end else if (cpu_ce) begin
			case (state)
				DMC_IDLE: begin
					// Only grab the bus when the CPU could be halted on a read
					if (dmc_req && cpu_rnw && !odd_cycle)
						state <= DMC_SLOT;
				end
				DMC_SLOT: begin
					if (!odd_cycle)
						state <= DMC_IDLE;   // Fetch cycle done
				end
				default: state <= DMC_IDLE;
			endcase
		end
	end

	// Fetch runs on the even cycle after the grant
	assign dmc_ack = (state == DMC_SLOT) && !odd_cycle;

endmodule

// File: src/dma_cycle_timer.sv
// CPU cycle timer
// Divides clk down to a one-clock CPU enable and tracks even/odd cycle parity
module dma_cycle_timer
	import nes_dma_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,      // One clk wide, every CPU_DIV clocks
	output logic odd_cycle    // 1 = current CPU cycle is odd
);

	div_cnt_t div_cnt;   // Position within the CPU cycle

	// Divider and enable pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			cpu_ce <= 1'b0;
		end else if (div_cnt == CPU_DIV - 4'd1) begin
			div_cnt <= '0;
			cpu_ce <= 1'b1;   // Last clock of the CPU cycle
		end else begin
			div_cnt <= div_cnt + 4'd1;
			cpu_ce <= 1'b0;
		end
	end

	// Parity flips as each CPU cycle completes
	// First cycle after reset counts as odd
	always_ff @(posedge clk) begin
		if (reset)
			odd_cycle <= 1'b1;
		else if (cpu_ce)
			odd_cycle <= ~odd_cycle;
	end

endmodule

// File: src/nes_dma_pkg.sv
// NES DMA shared definitions
// Bus widths, register addresses, the CPU bus struct and DMA state encodings
package nes_dma_pkg;

	// Data path widths
	typedef logic [15:0] addr_t;      // CPU address
	typedef logic [7:0]  byte_t;      // CPU data byte
	typedef logic [3:0]  div_cnt_t;   // Master clocks within one CPU cycle

	// Master clocks per CPU cycle
	localparam div_cnt_t CPU_DIV = 4'd12;

	// Writing the page number here kicks off sprite DMA
	localparam addr_t OAM_TRIGGER_ADDR = 16'h4014;
	// Every sprite DMA write lands on the PPU OAM data port
	localparam addr_t OAM_DATA_ADDR = 16'h2004;

	// One bus request or the resulting memory bus
	typedef struct packed {
		addr_t addr;   // Address to access
		byte_t data;   // Write data
		logic  rnw;    // 1 = read, 0 = write
	} cpu_bus_t;

	// Sprite DMA states
	typedef enum logic [1:0] {
		OAM_IDLE  = 2'd0,
		OAM_ARMED = 2'd1,   // Waiting for a CPU read on an odd cycle
		OAM_COPY  = 2'd3    // Moving bytes, owns the bus
	} oam_state_e;

	// DMC sample fetch states
	typedef enum logic {
		DMC_IDLE = 1'b0,
		DMC_SLOT = 1'b1     // Granted, fetch happens on the next even cycle
	} dmc_state_e;

endpackage
